//--- vga_pkg.sv
/*
  Shared types and register offsets for the VGA framebuffer peripheral.
  Imported by the bus decode, the framebuffer, the scan-out path and the testbench.
*/
`default_nettype none

package vga_pkg;

  // one framebuffer pixel, 8 bits of colour.
  typedef logic [7:0] pixel_t;

  // cpu data bus word, used for daddr, din and dout.
  typedef logic [31:0] bus_word_t;

  // which register slot a cpu access hits.
  typedef enum logic [1:0] {
    reg_data,
    reg_row,
    reg_col,
    reg_flat
  } bus_reg_e;

  // byte offsets of the register slots.
  // the data slot sits at offset 0.
  localparam bus_word_t reg_row_addr = 32'd4;
  localparam bus_word_t reg_col_addr = 32'd8;

  // flat access starts here, pixel index is the offset above it.
  localparam bus_word_t reg_flat_base = 32'd12;

endpackage : vga_pkg

`default_nettype wire

//--- vga_timing.sv
/*
  Horizontal and vertical scan counters for the VGA output.
  Gives screen position, the active-area flag and raw active-low syncs.
*/
`timescale 1ns/100ps
`default_nettype none

module vga_timing #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 29
) (
  input  wire logic        clka,
  input  wire logic        rst,
  output logic [10:0]      h_pos,
  output logic [10:0]      v_pos,
  output logic             active,
  output logic             hs_raw,
  output logic             vs_raw
);

  // each line runs sync, back porch, active, front porch.
  localparam logic [10:0] h_total = 11'(h_sync + h_back + h_active + h_front);
  localparam logic [10:0] h_start = 11'(h_sync + h_back);
  localparam logic [10:0] h_end   = 11'(h_sync + h_back + h_active);
  localparam logic [10:0] v_total = 11'(v_sync + v_back + v_active + v_front);
  localparam logic [10:0] v_start = 11'(v_sync + v_back);
  localparam logic [10:0] v_end   = 11'(v_sync + v_back + v_active);

  logic [10:0] h_cnt;
  logic [10:0] v_cnt;
  logic        h_wrap;
  logic        h_act;
  logic        v_act;

  assign h_wrap = (h_cnt == h_total - 11'd1);

  always_ff @(posedge clka) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      h_cnt <= h_wrap ? '0 : h_cnt + 11'd1;
      // line counter steps once per full line.
      if (h_wrap) begin
        v_cnt <= (v_cnt == v_total - 11'd1) ? '0 : v_cnt + 11'd1;
      end
    end
  end

  assign h_act  = (h_cnt >= h_start) && (h_cnt < h_end);
  assign v_act  = (v_cnt >= v_start) && (v_cnt < v_end);
  assign active = h_act && v_act;

  // offsets within the active area, zero outside it.
  assign h_pos = h_act ? h_cnt - h_start : '0;
  assign v_pos = v_act ? v_cnt - v_start : '0;

  // syncs are low for the first part of each period.
  assign hs_raw = !(h_cnt < 11'(h_sync));
  assign vs_raw = !(v_cnt < 11'(v_sync));

endmodule : vga_timing

`default_nettype wire

//--- vga_framebuffer.sv
/*
  Dual-port pixel memory, one port for the CPU and one for scan-out.
  Both reads are registered; out-of-range addresses read zero and never write.
*/
`timescale 1ns/100ps
`default_nettype none

module vga_framebuffer #(
  parameter  int depth  = 76800,
  localparam int addr_w = $clog2(depth + 1)
) (
  input  wire logic              clka,
  input  wire logic [addr_w-1:0] cpu_addr,
  input  wire logic              cpu_we,
  input  wire vga_pkg::pixel_t   cpu_wdata,
  output vga_pkg::pixel_t        cpu_rdata,
  input  wire logic [addr_w-1:0] scan_addr,
  output vga_pkg::pixel_t        scan_rdata
);

  import vga_pkg::*;

  pixel_t mem [depth];

  // cpu port reads the old contents in a write cycle.
  always_ff @(posedge clka) begin
    cpu_rdata <= (cpu_addr < depth) ? mem[cpu_addr] : '0;
    if (cpu_we && (cpu_addr < depth)) begin
      mem[cpu_addr] <= cpu_wdata;
    end
  end

  always_ff @(posedge clka) begin
    scan_rdata <= (scan_addr < depth) ? mem[scan_addr] : '0;
  end

endmodule : vga_framebuffer

`default_nettype wire

//--- vga_bus_regs.sv
/*
  CPU data port of the VGA peripheral: slot decode, row and col registers,
  framebuffer address generation and the registered read data.
*/
`timescale 1ns/100ps
`default_nettype none

module vga_bus_regs #(
  parameter  int h_active = 640,
  parameter  int v_active = 480,
  localparam int fb_depth = (h_active / 2) * (v_active / 2),
  localparam int addr_w   = $clog2(fb_depth + 1)
) (
  input  wire logic              clka,
  input  wire logic              rst,
  input  wire logic              de,
  input  wire logic              drw,
  input  wire vga_pkg::bus_word_t daddr,
  input  wire vga_pkg::bus_word_t din,
  output vga_pkg::bus_word_t     dout,
  output logic [addr_w-1:0]      fb_addr,
  output logic                   fb_we,
  output vga_pkg::pixel_t        fb_wdata,
  input  wire vga_pkg::pixel_t   fb_rdata
);

  import vga_pkg::*;

  localparam int fb_width = h_active / 2;

  bus_reg_e    sel;
  bus_reg_e    rd_sel;
  logic        rd_pend;
  logic [15:0] row_r;
  logic [15:0] col_r;
  logic [15:0] rd_reg;
  bus_word_t   pix_idx;

  // each slot covers its whole word, anything from the flat base up is flat.
  always_comb begin
    if (daddr >= reg_flat_base)     sel = reg_flat;
    else if (daddr >= reg_col_addr) sel = reg_col;
    else if (daddr >= reg_row_addr) sel = reg_row;
    else                            sel = reg_data;
  end

  assign pix_idx = (sel == reg_flat) ? daddr - reg_flat_base
                                     : 32'(row_r) * 32'(fb_width) + 32'(col_r);

  // indices past the end are pinned to depth, which the memory ignores.
  assign fb_addr  = (pix_idx < fb_depth) ? pix_idx[addr_w-1:0] : addr_w'(fb_depth);
  assign fb_we    = de && drw && ((sel == reg_data) || (sel == reg_flat));
  assign fb_wdata = din[7:0];

  always_ff @(posedge clka) begin
    if (rst) begin
      row_r   <= '0;
      col_r   <= '0;
      rd_pend <= 1'b0;
      rd_sel  <= reg_data;
    end else begin
      if (de && drw && (sel == reg_row)) row_r <= din[15:0];
      if (de && drw && (sel == reg_col)) col_r <= din[15:0];
      rd_pend <= de && !drw;
      if (de && !drw) rd_sel <= sel;
    end
  end

  // register value is taken on the read edge, next to the memory read.
  always_ff @(posedge clka) begin
    if (de && !drw) begin
      rd_reg <= (sel == reg_row) ? row_r : col_r;
    end
  end

  // read data lands one edge after the request and holds until the next read.
  always_ff @(posedge clka) begin
    if (rst) begin
      dout <= '0;
    end else if (rd_pend) begin
      case (rd_sel)
        reg_row, reg_col: dout <= {16'd0, rd_reg};
        default:          dout <= {24'd0, fb_rdata};
      endcase
    end
  end

endmodule : vga_bus_regs

`default_nettype wire

//--- vga_scan_out.sv
/*
  Scan-out path: maps screen position to a framebuffer address, lines the
  syncs up with the memory read, and registers the video outputs.
*/
`timescale 1ns/100ps
`default_nettype none

module vga_scan_out #(
  parameter  int h_active = 640,
  parameter  int v_active = 480,
  localparam int fb_depth = (h_active / 2) * (v_active / 2),
  localparam int addr_w   = $clog2(fb_depth + 1)
) (
  input  wire logic              clka,
  input  wire logic              rst,
  input  wire logic [10:0]       h_pos,
  input  wire logic [10:0]       v_pos,
  input  wire logic              active,
  input  wire logic              hs_raw,
  input  wire logic              vs_raw,
  output logic [addr_w-1:0]      scan_addr,
  input  wire vga_pkg::pixel_t   scan_rdata,
  output logic                   hs,
  output logic                   vs,
  output logic                   blank,
  output vga_pkg::pixel_t        rgb
);

  localparam int fb_width = h_active / 2;

  logic active_d;
  logic hs_d;
  logic vs_d;

  // each framebuffer pixel covers a 2x2 block on screen.
  assign scan_addr = addr_w'(32'(v_pos >> 1) * 32'(fb_width) + 32'(h_pos >> 1));

  // first stage runs alongside the memory read.
  always_ff @(posedge clka) begin
    if (rst) begin
      active_d <= 1'b0;
      hs_d     <= 1'b1;
      vs_d     <= 1'b1;
    end else begin
      active_d <= active;
      hs_d     <= hs_raw;
      vs_d     <= vs_raw;
    end
  end

  // second stage is the output register.
  always_ff @(posedge clka) begin
    if (rst) begin
      hs    <= 1'b1;
      vs    <= 1'b1;
      blank <= 1'b1;
      rgb   <= '0;
    end else begin
      hs    <= hs_d;
      vs    <= vs_d;
      blank <= !active_d;
      rgb   <= active_d ? scan_rdata : '0;
    end
  end

endmodule : vga_scan_out

`default_nettype wire

//--- vga_top.sv
/*
  Top level of the memory-mapped VGA peripheral.
  Set the eight timing parameters for the display mode; they flow down to the blocks.
*/
`timescale 1ns/100ps
`default_nettype none

module vga_top #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 29
) (
  input  wire logic               clka,
  input  wire logic               rst,
  input  wire logic               de,
  input  wire logic               drw,
  input  wire vga_pkg::bus_word_t daddr,
  input  wire vga_pkg::bus_word_t din,
  output vga_pkg::bus_word_t      dout,
  output vga_pkg::pixel_t         rgb,
  output logic                    hs,
  output logic                    vs,
  output logic                    blank
);

  import vga_pkg::*;

  // framebuffer is half the screen size in each axis.
  localparam int fb_depth  = (h_active / 2) * (v_active / 2);
  localparam int fb_addr_w = $clog2(fb_depth + 1);

  logic [10:0]          h_pos;
  logic [10:0]          v_pos;
  logic                 active;
  logic                 hs_raw;
  logic                 vs_raw;
  logic [fb_addr_w-1:0] fb_addr;
  logic                 fb_we;
  pixel_t               fb_wdata;
  pixel_t               fb_rdata;
  logic [fb_addr_w-1:0] scan_addr;
  pixel_t               scan_rdata;

  vga_timing #(
    .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
    .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
  ) u_timing (
    .clka(clka), .rst(rst), .h_pos(h_pos), .v_pos(v_pos), .active(active),
    .hs_raw(hs_raw), .vs_raw(vs_raw)
  );

  vga_bus_regs #(.h_active(h_active), .v_active(v_active)) u_bus_regs (
    .clka(clka), .rst(rst), .de(de), .drw(drw), .daddr(daddr), .din(din),
    .dout(dout), .fb_addr(fb_addr), .fb_we(fb_we), .fb_wdata(fb_wdata),
    .fb_rdata(fb_rdata)
  );

  vga_framebuffer #(.depth(fb_depth)) u_framebuffer (
    .clka(clka), .cpu_addr(fb_addr), .cpu_we(fb_we), .cpu_wdata(fb_wdata),
    .cpu_rdata(fb_rdata), .scan_addr(scan_addr), .scan_rdata(scan_rdata)
  );

  vga_scan_out #(.h_active(h_active), .v_active(v_active)) u_scan_out (
    .clka(clka), .rst(rst), .h_pos(h_pos), .v_pos(v_pos), .active(active),
    .hs_raw(hs_raw), .vs_raw(vs_raw), .scan_addr(scan_addr),
    .scan_rdata(scan_rdata), .hs(hs), .vs(vs), .blank(blank), .rgb(rgb)
  );

endmodule : vga_top

`default_nettype wire

//--- vga_sva.sv
/*
  Concurrent checks on the VGA video outputs, bound into vga_top.
*/
`timescale 1ns/100ps
`default_nettype none

module vga_sva #(
  parameter int h_sync = 96
) (
  input wire logic            clka,
  input wire logic            rst,
  input wire logic            hs,
  input wire logic            vs,
  input wire logic            blank,
  input wire vga_pkg::pixel_t rgb
);

  int err_count = 0;

  // colour is dark outside the active area.
  assert property (@(posedge clka) disable iff (rst) blank |-> rgb == '0)
    else begin
      err_count++;
      $error("rgb is not zero while blank is high");
    end

  // one sync pulse per line, h_sync clocks wide.
  assert property (@(posedge clka) disable iff (rst) $fell(hs) |-> (!hs)[*h_sync] ##1 hs)
    else begin
      err_count++;
      $error("hs pulse width differs from h_sync");
    end

  // the line counter only steps at the start of a line.
  assert property (@(posedge clka) disable iff (rst) $changed(vs) |-> $fell(hs))
    else begin
      err_count++;
      $error("vs changed away from a falling edge of hs");
    end

endmodule : vga_sva

bind vga_top vga_sva #(.h_sync(h_sync)) u_sva (
  .clka(clka), .rst(rst), .hs(hs), .vs(vs), .blank(blank), .rgb(rgb)
);

`default_nettype wire

//--- tb_vga.sv
/*
  Testbench for vga_top in a small video mode. Random bus traffic runs against a
  reference model, and the bus and video outputs are compared on every falling edge.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_vga;

  import vga_pkg::*;

  localparam int h_active = 32;
  localparam int h_front  = 4;
  localparam int h_sync   = 8;
  localparam int h_back   = 6;
  localparam int v_active = 24;
  localparam int v_front  = 2;
  localparam int v_sync   = 2;
  localparam int v_back   = 3;
  localparam int h_total  = h_sync + h_back + h_active + h_front;
  localparam int v_total  = v_sync + v_back + v_active + v_front;
  localparam int fb_w     = h_active / 2;
  localparam int fb_depth = fb_w * (v_active / 2);

  logic      clka;
  logic      rst;
  logic      de;
  logic      drw;
  bus_word_t daddr;
  bus_word_t din;
  bus_word_t dout;
  pixel_t    rgb;
  logic      hs;
  logic      vs;
  logic      blank;
  integer    seed;

  // reference model state.
  pixel_t      mem_m [fb_depth];
  logic [15:0] row_m;
  logic [15:0] col_m;
  int          h_m;
  int          v_m;
  logic [10:0] st1;
  logic [10:0] st2;
  logic        rd_pend;
  bus_word_t   rd_val;
  bus_word_t   dout_m;
  logic        started = 1'b0;

  vga_top #(
    .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
    .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
  ) u_dut (
    .clka(clka), .rst(rst), .de(de), .drw(drw), .daddr(daddr), .din(din),
    .dout(dout), .rgb(rgb), .hs(hs), .vs(vs), .blank(blank)
  );

  always #50 clka = ~clka;

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(string name, bus_word_t got, bus_word_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_pixel(string name, pixel_t got, pixel_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic bus_reg_e decode_slot(bus_word_t a);
    if (a >= reg_flat_base) return reg_flat;
    if (a >= reg_col_addr) return reg_col;
    if (a >= reg_row_addr) return reg_row;
    return reg_data;
  endfunction

  function automatic bus_word_t pixel_index(bus_word_t a);
    if (decode_slot(a) == reg_flat) return a - reg_flat_base;
    return 32'(row_m) * fb_w + 32'(col_m);
  endfunction

  function automatic bus_word_t read_model(bus_word_t a);
    bus_word_t idx;
    idx = pixel_index(a);
    case (decode_slot(a))
      reg_row: return {16'd0, row_m};
      reg_col: return {16'd0, col_m};
      default: return (idx < fb_depth) ? {24'd0, mem_m[idx]} : '0;
    endcase
  endfunction

  task automatic write_model(bus_word_t a, bus_word_t d);
    bus_word_t idx;
    idx = pixel_index(a);
    case (decode_slot(a))
      reg_row: row_m = d[15:0];
      reg_col: col_m = d[15:0];
      default: if (idx < fb_depth) mem_m[idx] = d[7:0];
    endcase
  endtask

  // expected {hs, vs, blank, rgb} for one counter position.
  function automatic logic [10:0] video_model(int h, int v);
    int     hp;
    int     vp;
    logic   act;
    pixel_t pix;
    hp  = h - (h_sync + h_back);
    vp  = v - (v_sync + v_back);
    act = (hp >= 0) && (hp < h_active) && (vp >= 0) && (vp < v_active);
    pix = act ? mem_m[(vp / 2) * fb_w + hp / 2] : 8'h00;
    return {h >= h_sync, v >= v_sync, !act, pix};
  endfunction

  // model steps on the rising edge.
  // scan reads see the memory from before this edge's write.
  always @(posedge clka) begin
    started = 1'b1;
    if (rst) begin
      h_m     = 0;
      v_m     = 0;
      st1     = {3'b111, 8'h00};
      st2     = st1;
      rd_pend = 1'b0;
      dout_m  = '0;
      row_m   = '0;
      col_m   = '0;
    end else begin
      st2 = st1;
      st1 = video_model(h_m, v_m);
      if (rd_pend) dout_m = rd_val;
      rd_pend = de && !drw;
      if (rd_pend) rd_val = read_model(daddr);
      if (de && drw) write_model(daddr, din);
      if (h_m == h_total - 1) begin
        h_m = 0;
        v_m = (v_m == v_total - 1) ? 0 : v_m + 1;
      end else begin
        h_m = h_m + 1;
      end
    end
  end

  // outputs, reset values included, are settled by the falling edge.
  always @(negedge clka) begin
    if (started) begin
      check_bit("hs", hs, st2[10]);
      check_bit("vs", vs, st2[9]);
      check_bit("blank", blank, st2[8]);
      check_word("dout", dout, dout_m);
      check_pixel("rgb", rgb, st2[7:0]);
    end
  end

  task automatic bus_access(logic wr, bus_word_t a, bus_word_t d);
    @(negedge clka);
    de    = 1'b1;
    drw   = wr;
    daddr = a;
    din   = d;
  endtask

  task automatic bus_idle(int n);
    repeat (n) begin
      @(negedge clka);
      de  = 1'b0;
      drw = 1'b0;
    end
  endtask

  initial begin
    #((3 * h_total * v_total + 600 + 4) * 100);
    stop_with_error("watchdog timeout, the run did not finish in time");
  end

  initial begin
    int        r;
    int        c;
    bus_word_t sel;
    seed  = 32'h5742;
    clka  = 1'b0;
    rst   = 1'b1;
    de    = 1'b0;
    drw   = 1'b0;
    daddr = '0;
    din   = '0;
    repeat (4) @(posedge clka);
    @(negedge clka);
    rst = 1'b0;

    // fill the whole framebuffer, then poke well past its end.
    for (int i = 0; i < fb_depth; i++) begin
      bus_access(1'b1, reg_flat_base + i, $random(seed));
    end
    repeat (8) begin
      bus_access(1'b1, reg_flat_base + fb_depth + {$random(seed)} % (4 * fb_depth),
                 $random(seed));
    end
    repeat (60) begin
      bus_access(1'b0, reg_flat_base + {$random(seed)} % (2 * fb_depth), '0);
    end
    bus_idle(3);

    // row and col readback, then data slot against the flat view.
    repeat (6) begin
      bus_access(1'b1, reg_row_addr, $random(seed));
      bus_access(1'b0, reg_row_addr, '0);
      bus_access(1'b1, reg_col_addr, $random(seed));
      bus_access(1'b0, reg_col_addr, '0);
    end
    repeat (12) begin
      r = {$random(seed)} % (v_active / 2);
      c = {$random(seed)} % fb_w;
      bus_access(1'b1, reg_row_addr, r);
      bus_access(1'b1, reg_col_addr, c);
      bus_access(1'b1, 32'd0, $random(seed));
      bus_access(1'b0, 32'd0, '0);
      bus_access(1'b0, reg_flat_base + r * fb_w + c, '0);
    end

    // two frames of scan-out with bus traffic alongside.
    repeat (2 * h_total * v_total) begin
      sel = $random(seed);
      if (sel[1:0] == 2'd0) begin
        bus_access(1'b1, reg_flat_base + {$random(seed)} % fb_depth, $random(seed));
      end else if (sel[1:0] == 2'd1) begin
        bus_access(1'b0, reg_flat_base + {$random(seed)} % fb_depth, '0);
      end else begin
        bus_idle(1);
      end
    end
    bus_idle(4);

    if (u_dut.u_sva.err_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_with_error("concurrent assertions failed during the run");
    end
  end

endmodule : tb_vga

`default_nettype wire

//--- sim.f
vga_pkg.sv
vga_timing.sv
vga_framebuffer.sv
vga_bus_regs.sv
vga_scan_out.sv
vga_top.sv
vga_sva.sv
tb_vga.sv
